// ==== hdl/core_pkg.sv ====
package core_pkg;

    localparam int XLEN          = 32;
    localparam int NUM_REGS      = 32;
    localparam int REG_IDX_W     = $clog2(NUM_REGS);
    localparam int IMM_W         = 12;
    localparam int OP_W          = 3;
    localparam int NUM_WR_STAGES = 3;             // Execute, memory, retire.

    typedef logic [XLEN-1:0]             t_xlen;
    typedef logic [REG_IDX_W-1:0]        t_reg_idx;
    typedef logic [NUM_REGS-1:0]         t_reg_mask;
    typedef logic signed [IMM_W-1:0]     t_imm;
    typedef logic [OP_W-1:0]             t_opcode;

    // Operation codes carried by the micro-op.
    localparam t_opcode OP_ADD  = 3'd0;
    localparam t_opcode OP_SUB  = 3'd1;
    localparam t_opcode OP_AND  = 3'd2;
    localparam t_opcode OP_XOR  = 3'd3;
    localparam t_opcode OP_ADDI = 3'd4;

    // One-hot register mask for a register index.
    // x0 is hardwired to zero, so it never appears in a mask.
    function automatic t_reg_mask idx_to_mask(input t_reg_idx idx);
        t_reg_mask mask;
        mask = '0;
        if (idx != '0) begin
            mask[idx] = 1'b1;
        end
        return mask;
    endfunction

    // Sign extension of the immediate to a full data word.
    function automatic t_xlen sext_imm(input t_imm imm);
        t_xlen word;
        word = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
        return word;
    endfunction

endpackage

// ==== hdl/core_top.sv ====
`timescale 1ns/10ps

module core_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  core_pkg::t_opcode  in_op,
    input  core_pkg::t_reg_idx in_rd,
    input  core_pkg::t_reg_idx in_rs1,
    input  core_pkg::t_reg_idx in_rs2,
    input  core_pkg::t_imm     in_imm,
    output logic               stall,
    output logic               retire_valid,
    output core_pkg::t_reg_idx retire_rd,
    output core_pkg::t_xlen    retire_value
);
    import core_pkg::*;

    t_reg_mask                     rd_mask;
    t_reg_mask [NUM_WR_STAGES-1:0] wr_masks;
    t_reg_idx                      rs1_addr;
    t_reg_idx                      rs2_addr;
    t_xlen                         rs1_data;
    t_xlen                         rs2_data;

    // Link k feeds writer stage k; the last link feeds the register file.
    uop_if stage_if [0:NUM_WR_STAGES] ();

    decode_read decode_read_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_rd    (in_rd),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_imm   (in_imm),
        .stall    (stall),
        .rd_mask  (rd_mask),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .issue    (stage_if[0])
    );

    scoreboard scoreboard_i (
        .rd_mask  (rd_mask),
        .wr_masks (wr_masks),
        .stall    (stall)
    );

    for (genvar i = 0; i < NUM_WR_STAGES; i++) begin : gen_writer
        writer_stage writer_i (
            .clk     (clk),
            .reset   (reset),
            .up      (stage_if[i]),
            .down    (stage_if[i+1]),
            .wr_mask (wr_masks[i])
        );
    end

    regfile_writeback regfile_i (
        .clk          (clk),
        .reset        (reset),
        .retire       (stage_if[NUM_WR_STAGES]),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

endmodule

// ==== hdl/decode_read.sv ====
`timescale 1ns/10ps

module decode_read (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  core_pkg::t_opcode   in_op,
    input  core_pkg::t_reg_idx  in_rd,
    input  core_pkg::t_reg_idx  in_rs1,
    input  core_pkg::t_reg_idx  in_rs2,
    input  core_pkg::t_imm      in_imm,
    input  logic                stall,
    output core_pkg::t_reg_mask rd_mask,
    output core_pkg::t_reg_idx  rs1_addr,
    output core_pkg::t_reg_idx  rs2_addr,
    input  core_pkg::t_xlen     rs1_data,
    input  core_pkg::t_xlen     rs2_data,
    uop_if.src                  issue
);
    import core_pkg::*;

    // Read stage contents.
    logic     rs_valid;
    t_opcode  rs_op;
    t_reg_idx rs_rd;
    t_reg_idx rs_rs1;
    t_reg_idx rs_rs2;
    t_imm     rs_imm;

    logic     uses_rs2;
    t_xlen    operand_b;
    t_xlen    result;

    // The read stage only moves when the scoreboard lets it go.
    always_ff @(posedge clk) begin
        if (reset) begin
            rs_valid <= 1'b0;
        end else if (!stall) begin
            rs_valid <= in_valid;                 // Empty if nothing was offered.
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rs_op  <= in_op;
            rs_rd  <= in_rd;
            rs_rs1 <= in_rs1;
            rs_rs2 <= in_rs2;
            rs_imm <= in_imm;
        end
    end

    assign uses_rs2 = (rs_op != OP_ADDI);         // ADDI takes the immediate instead.

    // Registers this stage is waiting to read.
    always_comb begin
        rd_mask = '0;
        if (rs_valid) begin
            rd_mask = idx_to_mask(rs_rs1);
            if (uses_rs2) begin
                rd_mask = rd_mask | idx_to_mask(rs_rs2);
            end
        end
    end

    assign rs1_addr = rs_rs1;
    assign rs2_addr = rs_rs2;

    assign operand_b = uses_rs2 ? rs2_data : sext_imm(rs_imm);

    always_comb begin
        case (rs_op)
            OP_ADD, OP_ADDI: result = rs1_data + operand_b;
            OP_SUB:          result = rs1_data - operand_b;
            OP_AND:          result = rs1_data & operand_b;
            OP_XOR:          result = rs1_data ^ operand_b;
            default:         result = '0;         // Unsupported code.
        endcase
    end

    // A stall sends a bubble down while the read stage keeps its micro-op.
    assign issue.valid  = rs_valid && !stall;
    assign issue.op     = rs_op;
    assign issue.rd     = rs_rd;
    assign issue.result = result;
    assign issue.wr_en  = issue.valid && (rs_rd != '0);

endmodule

// ==== hdl/regfile_writeback.sv ====
`timescale 1ns/10ps

module regfile_writeback (
    input  logic               clk,
    input  logic               reset,
    uop_if.dst                 retire,
    input  core_pkg::t_reg_idx rs1_addr,
    input  core_pkg::t_reg_idx rs2_addr,
    output core_pkg::t_xlen    rs1_data,
    output core_pkg::t_xlen    rs2_data,
    output logic               retire_valid,
    output core_pkg::t_reg_idx retire_rd,
    output core_pkg::t_xlen    retire_value
);
    import core_pkg::*;

    t_xlen regs [1:NUM_REGS-1];                   // x0 has no storage.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.wr_en) begin
            regs[retire.rd] <= retire.result;     // wr_en is never set for x0.
        end
    end

    // Asynchronous read ports.
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Every retiring micro-op is reported, including writes to x0.
    assign retire_valid = retire.valid;
    assign retire_rd    = retire.rd;
    assign retire_value = retire.result;

endmodule

// ==== hdl/scoreboard.sv ====
`timescale 1ns/10ps

module scoreboard (
    input  core_pkg::t_reg_mask                              rd_mask,
    input  core_pkg::t_reg_mask [core_pkg::NUM_WR_STAGES-1:0] wr_masks,
    output logic                                             stall
);
    import core_pkg::*;

    t_reg_mask pending_mask;                      // Registers with a write in flight.

    always_comb begin
        pending_mask = '0;
        for (int i = 0; i < NUM_WR_STAGES; i++) begin
            pending_mask = pending_mask | wr_masks[i];
        end
    end

    // Without forwarding the read stage must wait until every producer
    // of its sources has left the last writer stage.
    assign stall = |(rd_mask & pending_mask);

endmodule

// ==== hdl/uop_if.sv ====
`timescale 1ns/10ps

interface uop_if;
    import core_pkg::*;

    logic     valid;                              // Stage holds a live micro-op.
    t_opcode  op;
    t_reg_idx rd;                                 // Destination register.
    t_xlen    result;                             // Value computed in the read stage.
    logic     wr_en;                              // Valid and rd is not x0.

    modport src (
        output valid,
        output op,
        output rd,
        output result,
        output wr_en
    );

    modport dst (
        input  valid,
        input  op,
        input  rd,
        input  result,
        input  wr_en
    );

endinterface

// ==== hdl/writer_stage.sv ====
`timescale 1ns/10ps

module writer_stage (
    input  logic                clk,
    input  logic                reset,
    uop_if.dst                  up,
    uop_if.src                  down,
    output core_pkg::t_reg_mask wr_mask
);
    import core_pkg::*;

    // Control bits.
    always_ff @(posedge clk) begin
        if (reset) begin
            down.valid <= 1'b0;
            down.wr_en <= 1'b0;
        end else begin
            down.valid <= up.valid;
            down.wr_en <= up.wr_en;
        end
    end

    // Payload follows the control bits unconditionally.
    always_ff @(posedge clk) begin
        down.op     <= up.op;
        down.rd     <= up.rd;
        down.result <= up.result;
    end

    // Pending write of the micro-op held here, for the scoreboard.
    assign wr_mask = down.wr_en ? idx_to_mask(down.rd) : '0;

endmodule

// ==== test/core_assertions.sv ====
`timescale 1ns/10ps

module core_assertions (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic stall,
    input logic retire_valid
);

    // A stalled read stage was either just loaded or already held.
    property p_no_stall_when_empty;
        @(posedge clk) disable iff (reset) stall |-> $past(!reset && (in_valid || stall));
    endproperty

    property p_quiet_in_reset;
        @(posedge clk) reset ##1 reset |-> !retire_valid;
    endproperty

    // Accepted, then issued without a stall, then retired.
    property p_four_cycle_latency;
        @(posedge clk) disable iff (reset)
            (in_valid && !stall) ##1 !stall |-> ##3 retire_valid;
    endproperty

    assert property (p_no_stall_when_empty) else $error("stall high with an empty read stage");
    assert property (p_quiet_in_reset) else $error("retire_valid high during reset");
    assert property (p_four_cycle_latency) else $error("unstalled instruction missed 4 cycle retire");

endmodule

bind core_top core_assertions assertions_i (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .stall        (stall),
    .retire_valid (retire_valid)
);

// ==== test/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    localparam int NUM_ZERO_RD    = 16;       // ADDs into x0 that read every register.
    localparam int NUM_ENTRIES    = 20;
    localparam int NUM_RANDOM     = 200;
    localparam int NUM_EXPECTED   = NUM_ZERO_RD + NUM_ENTRIES + NUM_RANDOM;
    localparam int ISSUE_TIMEOUT  = 50;       // Cycles.
    localparam int RETIRE_TIMEOUT = 100;      // Cycles.

    typedef struct packed {
        t_opcode  op;
        t_reg_idx rd;
        t_reg_idx rs1;
        t_reg_idx rs2;
        t_imm     imm;
    } t_instr;

    logic     clk;
    logic     reset;
    logic     in_valid;
    t_opcode  in_op;
    t_reg_idx in_rd;
    t_reg_idx in_rs1;
    t_reg_idx in_rs2;
    t_imm     in_imm;
    logic     stall;
    logic     retire_valid;
    t_reg_idx retire_rd;
    t_xlen    retire_value;

    t_instr      stim_table [NUM_ENTRIES];
    t_xlen       model_regs [NUM_REGS];       // Committed register state of the model.
    int          ready_at [NUM_REGS];         // First read-stage cycle that sees the write.
    int          cycle_count;                 // Rising edges seen so far.
    int          stall_until;                 // Cycle the read-stage micro-op leaves.
    t_reg_idx    exp_rd_q [$];
    t_xlen       exp_val_q [$];
    logic [15:0] lfsr_state;

    core_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_next_bit();
        logic feedback;
        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_next_bit()};
        end
        return value;
    endfunction

    function automatic t_xlen model_result(input t_instr instr);
        t_xlen a;
        t_xlen b;
        a = model_regs[instr.rs1];
        if (instr.op == OP_ADDI) begin
            b = {{20{instr.imm[11]}}, instr.imm};   // Sign extended immediate.
        end else begin
            b = model_regs[instr.rs2];
        end
        case (instr.op)
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return a + b;              // ADD and ADDI.
        endcase
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
            stop_with_failure("A control output has the wrong level.");
        end
    endtask

    task automatic check_reg_idx(input string name, input t_reg_idx expected,
                                 input t_reg_idx actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
            stop_with_failure("Retired destination register differs from the model.");
        end
    endtask

    task automatic check_xlen(input string name, input t_xlen expected, input t_xlen actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %08h, actual %08h", $time, name, expected, actual);
            stop_with_failure("Retired value differs from the model.");
        end
    endtask

    // Called on a falling edge; returns on the falling edge after acceptance.
    task automatic issue_instr(input t_instr instr);
        int   waited;
        int   issue_at;
        logic taken;
        t_xlen value;
        in_valid = 1'b1;
        in_op    = instr.op;
        in_rd    = instr.rd;
        in_rs1   = instr.rs1;
        in_rs2   = instr.rs2;
        in_imm   = instr.imm;
        taken    = 1'b0;
        waited   = 0;
        while (!taken) begin
            if (waited == ISSUE_TIMEOUT) begin
                stop_with_failure("Timeout: stall never dropped for a held instruction.");
            end else begin
                check_bit("stall", cycle_count < stall_until, stall);
                taken = !stall;                 // Settled in the low half of the clock.
                @(posedge clk);
                @(negedge clk);
                waited++;
            end
        end
        in_valid = 1'b0;
        issue_at = cycle_count;                 // First cycle in the read stage.
        if (ready_at[instr.rs1] > issue_at) begin
            issue_at = ready_at[instr.rs1];
        end
        if (instr.op != OP_ADDI && ready_at[instr.rs2] > issue_at) begin
            issue_at = ready_at[instr.rs2];
        end
        stall_until = issue_at;
        value = model_result(instr);
        exp_rd_q.push_back(instr.rd);
        exp_val_q.push_back(value);
        if (instr.rd != '0) begin
            model_regs[instr.rd] = value;       // x0 stays zero.
            ready_at[instr.rd]   = issue_at + 4;
        end
    endtask

    task automatic run_stimulus();
        t_instr instr;
        for (int k = 0; k < NUM_ZERO_RD; k++) begin
            instr = '{OP_ADD, 5'd0, t_reg_idx'(2 * k), t_reg_idx'(2 * k + 1), 12'd0};
            issue_instr(instr);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            issue_instr(stim_table[i]);
        end
        // Registers x0 to x7 only, so hazards are frequent.
        for (int n = 0; n < NUM_RANDOM; n++) begin
            instr.op  = t_opcode'(lfsr_bits(3) % 5);
            instr.rd  = t_reg_idx'(lfsr_bits(3));
            instr.rs1 = t_reg_idx'(lfsr_bits(3));
            instr.rs2 = t_reg_idx'(lfsr_bits(3));
            instr.imm = t_imm'(lfsr_bits(12));
            if (lfsr_bits(1) == 1) begin
                @(negedge clk);                 // Idle cycle between instructions.
            end
            issue_instr(instr);
        end
    endtask

    task automatic run_checker();
        int retired;
        int idle;
        retired = 0;
        idle    = 0;
        while (retired < NUM_EXPECTED) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    stop_with_failure("retire_valid was high with no instruction outstanding.");
                end else begin
                    check_reg_idx("retire_rd", exp_rd_q.pop_front(), retire_rd);
                    check_xlen("retire_value", exp_val_q.pop_front(), retire_value);
                    retired++;
                    idle = 0;
                end
            end else if (idle == RETIRE_TIMEOUT) begin
                stop_with_failure("Timeout: no retire_valid for an outstanding instruction.");
            end else begin
                idle++;
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_op    = OP_ADD;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        lfsr_state  = 16'h0001;
        cycle_count = 0;
        stall_until = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
            ready_at[r]   = 0;
        end
        stim_table[0]  = '{OP_ADDI, 5'd1,  5'd0,  5'd0,  12'h123};
        stim_table[1]  = '{OP_ADDI, 5'd2,  5'd0,  5'd1,  12'hffb};  // rs2 unused by ADDI.
        stim_table[2]  = '{OP_ADDI, 5'd3,  5'd0,  5'd0,  12'h7ff};
        stim_table[3]  = '{OP_ADDI, 5'd4,  5'd0,  5'd0,  12'h800};  // Most negative.
        stim_table[4]  = '{OP_ADD,  5'd5,  5'd1,  5'd2,  12'h000};
        stim_table[5]  = '{OP_SUB,  5'd6,  5'd3,  5'd4,  12'h000};
        stim_table[6]  = '{OP_AND,  5'd7,  5'd2,  5'd3,  12'h000};
        stim_table[7]  = '{OP_XOR,  5'd8,  5'd1,  5'd4,  12'h000};
        stim_table[8]  = '{OP_ADDI, 5'd9,  5'd5,  5'd0,  12'h001};
        stim_table[9]  = '{OP_ADD,  5'd10, 5'd9,  5'd9,  12'h000};  // Distance 1.
        stim_table[10] = '{OP_ADDI, 5'd11, 5'd0,  5'd10, 12'd100};
        stim_table[11] = '{OP_ADDI, 5'd12, 5'd0,  5'd0,  12'd7};
        stim_table[12] = '{OP_SUB,  5'd13, 5'd11, 5'd0,  12'h000};  // Distance 2.
        stim_table[13] = '{OP_ADDI, 5'd14, 5'd0,  5'd0,  12'hfff};
        stim_table[14] = '{OP_ADDI, 5'd15, 5'd0,  5'd0,  12'd3};
        stim_table[15] = '{OP_ADDI, 5'd16, 5'd0,  5'd0,  12'd4};
        stim_table[16] = '{OP_XOR,  5'd17, 5'd14, 5'd1,  12'h000};  // Distance 3.
        stim_table[17] = '{OP_ADDI, 5'd0,  5'd1,  5'd0,  12'h055};  // Discarded write.
        stim_table[18] = '{OP_ADD,  5'd18, 5'd0,  5'd0,  12'h000};
        stim_table[19] = '{OP_SUB,  5'd19, 5'd0,  5'd1,  12'h000};
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("stall", 1'b0, stall);
        check_bit("retire_valid", 1'b0, retire_valid);
        fork
            run_stimulus();
            run_checker();
        join
        // No extra retires may follow the last one.
        repeat (20) begin
            @(negedge clk);
            check_bit("retire_valid", 1'b0, retire_valid);
        end
        if (exp_rd_q.size() != 0) begin
            stop_with_failure("Expected retires are left over at the end of the run.");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
hdl/core_pkg.sv
hdl/uop_if.sv
hdl/decode_read.sv
hdl/scoreboard.sv
hdl/writer_stage.sv
hdl/regfile_writeback.sv
hdl/core_top.sv
test/core_assertions.sv
test/core_tb.sv
